//--- logic/cmd_defs.svh
`ifndef CMD_DEFS_SVH
`define CMD_DEFS_SVH

// Bytes per command frame
`define CMD_FRAME_BYTES 4

// Byte buffer entries, also the sender's starting credit count
`define CMD_FIFO_DEPTH 8

// Downstream credits available after reset
`define CMD_RES_CREDITS 2

// Opcodes
`define CMD_OP_ADD 8'h01
`define CMD_OP_SUB 8'h02
`define CMD_OP_MUL 8'h03
`define CMD_OP_XOR 8'h04

`endif

//--- logic/cmd_pkg.sv
`default_nettype none

package cmd_pkg;

    typedef logic [7:0] byte_t;

    // Byte 0 sits in the top eight bits
    typedef logic [31:0] frame_t;

    typedef logic [7:0] tag_t;
    typedef logic [7:0] operand_t;
    typedef logic [15:0] value_t;

    // Buffer fill, wide enough to hold a full buffer
    typedef logic [3:0] fill_t;

    typedef logic [1:0] credit_t;

    typedef enum logic [1:0] {
        IDLE,
        READ,
        LAST,
        HOLD
    } reader_state_t;

endpackage

`default_nettype wire

//--- logic/byte_fifo.sv
`default_nettype none
`include "cmd_defs.svh"

module byte_fifo import cmd_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  in_valid,
    input  wire byte_t in_data,
    input  wire logic  rd_en,
    output byte_t      rd_data,
    output fill_t      fill,
    output logic       in_credit
);

    localparam int PTR_W = $clog2(`CMD_FIFO_DEPTH);

    byte_t mem [`CMD_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(`CMD_FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (in_valid) begin
            mem[wr_ptr] <= in_data;
        end
        if (rd_en) begin
            rd_data <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            fill      <= '0;
            in_credit <= 1'b0;
        end else begin
            if (in_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({in_valid, rd_en})
                2'b10:   fill <= fill + fill_t'(1);
                2'b01:   fill <= fill - fill_t'(1);
                default: fill <= fill;
            endcase
            // One credit back to the sender per popped byte
            in_credit <= rd_en;
        end
    end

endmodule

`default_nettype wire

//--- logic/frame_reader.sv
`default_nettype none
`include "cmd_defs.svh"

module frame_reader import cmd_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire fill_t fill,
    output logic       rd_en,
    input  wire byte_t rd_data,
    output logic       frame_valid,
    output frame_t     frame,
    input  wire logic  frame_ready
);

    reader_state_t state;
    reader_state_t state_next;

    logic [1:0] rd_cnt;
    logic [1:0] cap_cnt;
    logic       rd_q;

    assign rd_en = (state == READ) || (state == LAST);

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (fill >= fill_t'(`CMD_FRAME_BYTES)) begin
                    state_next = READ;
                end
            end
            READ: begin
                if (rd_cnt == 2'(`CMD_FRAME_BYTES - 2)) begin
                    state_next = LAST;
                end
            end
            LAST: state_next = HOLD;
            HOLD: begin
                if (frame_valid && frame_ready) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= IDLE;
            rd_cnt      <= '0;
            cap_cnt     <= '0;
            rd_q        <= 1'b0;
            frame_valid <= 1'b0;
        end else begin
            state <= state_next;
            rd_q  <= rd_en;
            if (state == READ) begin
                rd_cnt <= rd_cnt + 1'b1;
            end else begin
                rd_cnt <= '0;
            end
            // Read data lands one cycle after its rd_en
            if (rd_q) begin
                cap_cnt <= cap_cnt + 1'b1;
                if (cap_cnt == 2'(`CMD_FRAME_BYTES - 1)) begin
                    frame_valid <= 1'b1;
                end
            end
            if (frame_valid && frame_ready) begin
                frame_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_q) begin
            frame[(`CMD_FRAME_BYTES - 1 - cap_cnt) * 8 +: 8] <= rd_data;
        end
    end

endmodule

`default_nettype wire

//--- logic/cmd_decode.sv
`default_nettype none
`include "cmd_defs.svh"

module cmd_decode import cmd_pkg::*; (
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   frame_valid,
    input  wire frame_t frame,
    output logic        frame_ready,
    output logic        op_valid,
    output byte_t       opcode,
    output tag_t        tag,
    output operand_t    opa,
    output operand_t    opb,
    output logic        bad_op,
    input  wire logic   op_ready
);

    function automatic logic known_op(input byte_t op);
        case (op)
            `CMD_OP_ADD, `CMD_OP_SUB, `CMD_OP_MUL, `CMD_OP_XOR: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // Empty, or the held command leaves this cycle
    assign frame_ready = !op_valid || op_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            op_valid <= 1'b0;
        end else if (frame_ready) begin
            op_valid <= frame_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (frame_valid && frame_ready) begin
            opcode <= frame[31:24];
            tag    <= frame[23:16];
            opa    <= frame[15:8];
            opb    <= frame[7:0];
            bad_op <= !known_op(frame[31:24]);
        end
    end

endmodule

`default_nettype wire

//--- logic/alu_execute.sv
`default_nettype none
`include "cmd_defs.svh"

module alu_execute import cmd_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     op_valid,
    input  wire byte_t    opcode,
    input  wire tag_t     tag,
    input  wire operand_t opa,
    input  wire operand_t opb,
    input  wire logic     bad_op,
    output logic          op_ready,
    output logic          exe_valid,
    output tag_t          exe_tag,
    output value_t        exe_value,
    output logic          exe_err,
    input  wire logic     exe_ready
);

    value_t a_ext;
    value_t b_ext;
    value_t value;

    assign a_ext = value_t'(opa);
    assign b_ext = value_t'(opb);

    always_comb begin
        case (opcode)
            `CMD_OP_ADD: value = a_ext + b_ext;
            // Wraps modulo 2^16 when a is below b
            `CMD_OP_SUB: value = a_ext - b_ext;
            `CMD_OP_MUL: value = a_ext * b_ext;
            `CMD_OP_XOR: value = a_ext ^ b_ext;
            default:     value = '0;
        endcase
    end

    assign op_ready = !exe_valid || exe_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            exe_valid <= 1'b0;
        end else if (op_ready) begin
            exe_valid <= op_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (op_valid && op_ready) begin
            exe_tag   <= tag;
            exe_value <= value;
            exe_err   <= bad_op;
        end
    end

endmodule

`default_nettype wire

//--- logic/result_issue.sv
`default_nettype none
`include "cmd_defs.svh"

module result_issue import cmd_pkg::*; (
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   exe_valid,
    input  wire tag_t   exe_tag,
    input  wire value_t exe_value,
    input  wire logic   exe_err,
    output logic        exe_ready,
    output logic        res_valid,
    output tag_t        res_tag,
    output value_t      res_value,
    output logic        res_err,
    input  wire logic   res_credit
);

    logic    pending;
    credit_t credits;

    // A held result goes out as soon as a credit is available
    assign res_valid = pending && (credits != '0);
    assign exe_ready = !pending || res_valid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending <= 1'b0;
            credits <= credit_t'(`CMD_RES_CREDITS);
        end else begin
            if (exe_ready) begin
                pending <= exe_valid;
            end
            case ({res_valid, res_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (exe_valid && exe_ready) begin
            res_tag   <= exe_tag;
            res_value <= exe_value;
            res_err   <= exe_err;
        end
    end

endmodule

`default_nettype wire

//--- logic/cmd_engine.sv
`default_nettype none

module cmd_engine import cmd_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  in_valid,
    input  wire byte_t in_data,
    output logic       in_credit,
    output logic       res_valid,
    output tag_t       res_tag,
    output value_t     res_value,
    output logic       res_err,
    input  wire logic  res_credit
);

    byte_t    rd_data;
    fill_t    fill;
    logic     rd_en;

    logic     frame_valid;
    frame_t   frame;
    logic     frame_ready;

    logic     op_valid;
    byte_t    opcode;
    tag_t     tag;
    operand_t opa;
    operand_t opb;
    logic     bad_op;
    logic     op_ready;

    logic     exe_valid;
    tag_t     exe_tag;
    value_t   exe_value;
    logic     exe_err;
    logic     exe_ready;

    byte_fifo fifo0 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .rd_en     (rd_en),
        .rd_data   (rd_data),
        .fill      (fill),
        .in_credit (in_credit)
    );

    frame_reader reader0 (
        .clk         (clk),
        .rst         (rst),
        .fill        (fill),
        .rd_en       (rd_en),
        .rd_data     (rd_data),
        .frame_valid (frame_valid),
        .frame       (frame),
        .frame_ready (frame_ready)
    );

    cmd_decode decode0 (
        .clk         (clk),
        .rst         (rst),
        .frame_valid (frame_valid),
        .frame       (frame),
        .frame_ready (frame_ready),
        .op_valid    (op_valid),
        .opcode      (opcode),
        .tag         (tag),
        .opa         (opa),
        .opb         (opb),
        .bad_op      (bad_op),
        .op_ready    (op_ready)
    );

    alu_execute execute0 (
        .clk       (clk),
        .rst       (rst),
        .op_valid  (op_valid),
        .opcode    (opcode),
        .tag       (tag),
        .opa       (opa),
        .opb       (opb),
        .bad_op    (bad_op),
        .op_ready  (op_ready),
        .exe_valid (exe_valid),
        .exe_tag   (exe_tag),
        .exe_value (exe_value),
        .exe_err   (exe_err),
        .exe_ready (exe_ready)
    );

    result_issue issue0 (
        .clk        (clk),
        .rst        (rst),
        .exe_valid  (exe_valid),
        .exe_tag    (exe_tag),
        .exe_value  (exe_value),
        .exe_err    (exe_err),
        .exe_ready  (exe_ready),
        .res_valid  (res_valid),
        .res_tag    (res_tag),
        .res_value  (res_value),
        .res_err    (res_err),
        .res_credit (res_credit)
    );

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 100ps;

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

//--- testbench/cmd_engine_tb.sv
`default_nettype none
`include "cmd_defs.svh"

module cmd_engine_tb import cmd_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_CMDS  = 12;
    localparam int NUM_BYTES = NUM_CMDS * `CMD_FRAME_BYTES;

    typedef struct packed {
        byte_t    op;
        tag_t     tag;
        operand_t a;
        operand_t b;
        value_t   value;
        logic     err;
    } cmd_row_t;

    logic     clk;
    logic     rst;
    logic     in_valid;
    byte_t    in_data;
    logic     in_credit;
    logic     res_valid;
    tag_t     res_tag;
    value_t   res_value;
    logic     res_err;
    logic     res_credit;

    cmd_row_t    cmd_table [NUM_CMDS];
    int          value_errors = 0;
    int          other_errors = 0;
    int          bytes_sent = 0;
    int          credit_pulses = 0;
    int          results_seen = 0;
    int          results_issued = 0;
    int          credits_granted = 0;
    int          credits_owed = 0;
    int          credit_delay = 0;
    logic        withhold;
    logic [31:0] send_rng;
    logic [31:0] cons_rng;

    tb_clock clock0 (
        .clk (clk),
        .rst (rst)
    );

    cmd_engine dut0 (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_credit  (in_credit),
        .res_valid  (res_valid),
        .res_tag    (res_tag),
        .res_value  (res_value),
        .res_err    (res_err),
        .res_credit (res_credit)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic byte_t stream_byte(input int idx);
        cmd_row_t row;
        row = cmd_table[idx / `CMD_FRAME_BYTES];
        case (idx % `CMD_FRAME_BYTES)
            0: return row.op;
            1: return row.tag;
            2: return row.a;
            default: return row.b;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic report_failure(input string msg);
        other_errors++;
        $display("ERROR %s", msg);
    endtask

    task automatic print_counts();
        $display("Errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
    endtask

    task automatic abort_on_timeout(input string what);
        report_failure({"timeout while waiting for ", what});
        print_counts();
        $display("SOME TESTS FAILED");
        $finish;
    endtask

    // opcode, tag, a, b, expected value, expected err
    initial begin
        cmd_table[0]  = {`CMD_OP_ADD, 8'h10, 8'h12, 8'h34, 16'h0046, 1'b0};
        cmd_table[1]  = {`CMD_OP_SUB, 8'h11, 8'h50, 8'h20, 16'h0030, 1'b0};
        // a below b wraps
        cmd_table[2]  = {`CMD_OP_SUB, 8'h12, 8'h05, 8'h07, 16'hfffe, 1'b0};
        cmd_table[3]  = {`CMD_OP_MUL, 8'h13, 8'hff, 8'hff, 16'hfe01, 1'b0};
        cmd_table[4]  = {`CMD_OP_XOR, 8'h14, 8'ha5, 8'h3c, 16'h0099, 1'b0};
        cmd_table[5]  = {8'h07,       8'h15, 8'h11, 8'h22, 16'h0000, 1'b1};
        cmd_table[6]  = {`CMD_OP_ADD, 8'h16, 8'hff, 8'hff, 16'h01fe, 1'b0};
        cmd_table[7]  = {`CMD_OP_MUL, 8'h17, 8'h10, 8'h0c, 16'h00c0, 1'b0};
        cmd_table[8]  = {8'h00,       8'h18, 8'h01, 8'h01, 16'h0000, 1'b1};
        cmd_table[9]  = {`CMD_OP_XOR, 8'h19, 8'hf0, 8'h0f, 16'h00ff, 1'b0};
        cmd_table[10] = {`CMD_OP_SUB, 8'h1a, 8'h00, 8'hff, 16'hff01, 1'b0};
        cmd_table[11] = {`CMD_OP_MUL, 8'h1b, 8'h80, 8'h02, 16'h0100, 1'b0};
    end

    // Consumer credit model
    always @(posedge clk) begin
        if (rst) begin
            res_credit <= 1'b0;
        end else begin
            res_credit <= 1'b0;
            if (res_valid) begin
                results_issued++;
                credits_owed++;
                if (results_issued > `CMD_RES_CREDITS + credits_granted) begin
                    report_failure("result issued without a downstream credit");
                end
            end
            if (res_credit) begin
                credits_granted++;
            end
            if (!withhold && credits_owed > 0) begin
                if (credit_delay == 0) begin
                    res_credit <= 1'b1;
                    credits_owed--;
                    cons_rng = xorshift32(cons_rng);
                    credit_delay = cons_rng % 5;
                end else begin
                    credit_delay--;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (!rst && in_credit) begin
            credit_pulses <= credit_pulses + 1;
        end
    end

    // Results must come back in table order
    always @(posedge clk) begin
        if (!rst && res_valid) begin
            if (results_seen < NUM_CMDS) begin
                check_value($sformatf("res_tag[%0d]", results_seen), res_tag,
                            cmd_table[results_seen].tag);
                check_value($sformatf("res_value[%0d]", results_seen), res_value,
                            cmd_table[results_seen].value);
                check_value($sformatf("res_err[%0d]", results_seen), res_err,
                            cmd_table[results_seen].err);
            end else begin
                report_failure("more results arrived than commands were sent");
            end
            results_seen++;
        end
    end

    initial begin
        int i;
        int gap;
        int avail;
        int wait_cycles;
        in_valid   = 1'b0;
        in_data    = '0;
        res_credit = 1'b0;
        withhold   = 1'b1;
        send_rng   = 32'hcfd6;
        cons_rng   = xorshift32(xorshift32(32'hcfd6));

        wait_cycles = 0;
        while (rst !== 1'b0) begin
            @(posedge clk);
            wait_cycles++;
            if (wait_cycles > 50) abort_on_timeout("reset release");
        end

        // Idle engine, nothing may come out
        for (i = 0; i < 20; i++) begin
            @(negedge clk);
            check_value("in_credit", in_credit, 1'b0);
            check_value("res_valid", res_valid, 1'b0);
        end

        fork
            begin
                i = 0;
                gap = 0;
                wait_cycles = 0;
                while (i < NUM_BYTES) begin
                    @(posedge clk);
                    avail = `CMD_FIFO_DEPTH + credit_pulses - bytes_sent;
                    in_valid <= 1'b0;
                    if (avail > `CMD_FIFO_DEPTH) begin
                        report_failure("buffer returned more credits than bytes sent");
                    end
                    if (gap > 0) begin
                        gap--;
                    end else if (avail > 0) begin
                        in_valid <= 1'b1;
                        in_data  <= stream_byte(i);
                        bytes_sent++;
                        i++;
                        wait_cycles = 0;
                        send_rng = xorshift32(send_rng);
                        gap = (send_rng[1:0] == 2'b00) ? int'(send_rng[4:2]) : 0;
                    end
                    wait_cycles++;
                    if (wait_cycles > 1000) abort_on_timeout("a sender credit");
                end
                @(posedge clk);
                in_valid <= 1'b0;
            end
            begin
                // Long stretch without downstream credits
                for (int k = 0; k < 250; k++) @(negedge clk);
                check_value("results_seen", results_seen, `CMD_RES_CREDITS);
                if (bytes_sent >= NUM_BYTES) begin
                    report_failure("sender was not stalled by back-pressure");
                end
                withhold = 1'b0;
            end
        join

        wait_cycles = 0;
        while (results_seen < NUM_CMDS) begin
            @(negedge clk);
            wait_cycles++;
            if (wait_cycles > 2000) abort_on_timeout("all results");
        end
        wait_cycles = 0;
        while (credit_pulses < bytes_sent) begin
            @(negedge clk);
            wait_cycles++;
            if (wait_cycles > 100) abort_on_timeout("the last buffer credits");
        end
        // Extra cycles to catch a duplicated result or credit
        for (i = 0; i < 40; i++) @(negedge clk);

        check_value("results_seen", results_seen, NUM_CMDS);
        check_value("credit_pulses", credit_pulses, NUM_BYTES);
        print_counts();
        if (value_errors == 0 && other_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+logic
logic/cmd_pkg.sv
logic/byte_fifo.sv
logic/frame_reader.sv
logic/cmd_decode.sv
logic/alu_execute.sv
logic/result_issue.sv
logic/cmd_engine.sv
testbench/tb_clock.sv
testbench/cmd_engine_tb.sv

//--- Bender.yml
package:
  name: cmd_engine

sources:
  - include_dirs:
      - logic
    files:
      - logic/cmd_pkg.sv
      - logic/byte_fifo.sv
      - logic/frame_reader.sv
      - logic/cmd_decode.sv
      - logic/alu_execute.sv
      - logic/result_issue.sv
      - logic/cmd_engine.sv
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/tb_clock.sv
      - testbench/cmd_engine_tb.sv
